//--- hdl/convPkg.sv
//--------------------
// conversion unit types
// register word and op codes shared by the lanes
//--------------------
package convPkg;

	// one 64-bit register value
	typedef logic [63:0] convWord_t;

	// codes 21 to 31 are undefined and give zero
	typedef enum logic [4:0] {
		opMov        = 5'd0,
		opNot        = 5'd1,
		opExtSb      = 5'd2,
		opExtSw      = 5'd3,
		opExtSl      = 5'd4,
		opExtUb      = 5'd5,
		opExtUw      = 5'd6,
		opExtUl      = 5'd7,
		// immediate high-part loaders
		opLdiHi      = 5'd8,
		opLdiQHi     = 5'd9,
		opLdiQHi16   = 5'd10,
		opLdiQHi32   = 5'd11,
		opFNeg       = 5'd12,
		opFAbs       = 5'd13,
		// pixel ops
		opRgbShr1    = 5'd14,
		opRgb5Pck32  = 5'd15,
		opRgb5Upck32 = 5'd16,
		opRgb5Pck64  = 5'd17,
		opRgb5Upck64 = 5'd18,
		opRgb32Pck64 = 5'd19,
		opRgb32Upck64 = 5'd20
	} convOp_t;

endpackage

//--- hdl/convLaneIf.sv
//--------------------
// dispatcher to lane channel
// valid/ready handshake with op and operand
//--------------------
interface convLaneIf
	import convPkg::*;
();

	logic      valid;
	convOp_t   op;
	convWord_t val;
	logic      ready;

	modport src (
		output valid,
		output op,
		output val,
		input  ready
	);

	modport dst (
		input  valid,
		input  op,
		input  val,
		output ready
	);

endinterface

//--- hdl/convDispatch.sv
//--------------------
// conversion dispatcher
// round-robin issue of operations to the lanes
//--------------------
module convDispatch
	import convPkg::*;
#(
	parameter int NumLanes = 4
) (
	input  logic      clock,
	input  logic      arstN,
	input  logic      inValid,
	input  convOp_t   inOp,
	input  convWord_t inVal,
	output logic      inReady,
	convLaneIf.src    lanes [NumLanes]
);

	localparam int PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	typedef logic [PtrW-1:0] lanePtr_t;

	lanePtr_t            issuePtr;
	logic [NumLanes-1:0] laneReady;

	for (genvar i = 0; i < NumLanes; i++) begin : genLane
		// only the pointed lane sees the valid
		assign lanes[i].valid = inValid && (issuePtr == lanePtr_t'(i));
		assign lanes[i].op    = inOp;
		assign lanes[i].val   = inVal;
		assign laneReady[i]   = lanes[i].ready;
	end

	assign inReady = laneReady[issuePtr];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			issuePtr <= '0;
		end else if (inValid && inReady) begin
			if (issuePtr == lanePtr_t'(NumLanes - 1)) begin
				issuePtr <= '0;
			end else begin
				issuePtr <= issuePtr + lanePtr_t'(1);
			end
		end
	end

endmodule

//--- hdl/convLane.sv
//--------------------
// conversion lane
// decodes one op and holds its result until drained
//--------------------
module convLane
	import convPkg::*;
(
	input  logic      clock,
	input  logic      arstN,
	convLaneIf.dst    req,
	output logic      resValid,
	output convWord_t resVal,
	input  logic      resReady
);

	logic      full;
	convWord_t resReg;
	convWord_t convVal;
	convWord_t src;
	logic [31:0] rgb5Upck32;

	assign src = req.val;

	// 555 to 8888 with alpha from bit 15
	assign rgb5Upck32 = {
		src[15] ? {src[10], src[5], src[0], 5'b0} : 8'hFF,
		src[14:10], src[14:12],
		src[ 9: 5], src[ 9: 7],
		src[ 4: 0], src[ 4: 2]
	};

	always_comb begin
		convVal = '0;
		case (req.op)
			opMov:   convVal = src;
			opNot:   convVal = ~src;
			opExtSb: convVal = {{56{src[7]}}, src[7:0]};
			opExtSw: convVal = {{48{src[15]}}, src[15:0]};
			opExtSl: convVal = {{32{src[31]}}, src[31:0]};
			opExtUb: convVal = {56'b0, src[7:0]};
			opExtUw: convVal = {48'b0, src[15:0]};
			opExtUl: convVal = {32'b0, src[31:0]};

			opLdiHi:    convVal = {src[41:0], 22'b0};
			opLdiQHi:   convVal = {src[9:0], 54'b0};
			opLdiQHi16: convVal = {src[47:0], 16'b0};
			opLdiQHi32: convVal = {src[31:0], 32'b0};

			// sign bit only
			opFNeg: convVal = {~src[63], src[62:0]};
			opFAbs: convVal = {1'b0, src[62:0]};

			opRgbShr1: begin
				convVal = {48'b0, 1'b0,
					1'b0, src[14:11],
					1'b0, src[ 9: 6],
					1'b0, src[ 4: 1]};
			end
			opRgb5Pck32: begin
				convVal = {48'b0, 1'b0, src[23:19], src[15:11], src[7:3]};
				// translucent pixels keep three alpha bits
				if (src[31:28] != 4'hF) begin
					convVal[15] = 1'b1;
					convVal[10] = src[31];
					convVal[5]  = src[30];
					convVal[0]  = src[29];
				end
			end
			opRgb5Upck32: convVal = {32'b0, rgb5Upck32};
			opRgb5Pck64: begin
				convVal = {48'b0, 1'b0, src[47:43], src[31:27], src[15:11]};
				if (src[63:60] != 4'hF) begin
					convVal[15] = 1'b1;
					convVal[10] = src[63];
					convVal[5]  = src[62];
					convVal[0]  = src[61];
				end
			end
			opRgb5Upck64: begin
				convVal = {
					rgb5Upck32[31:24], rgb5Upck32[31:24],
					rgb5Upck32[23:16], rgb5Upck32[23:16],
					rgb5Upck32[15: 8], rgb5Upck32[15: 8],
					rgb5Upck32[ 7: 0], rgb5Upck32[ 7: 0]
				};
			end
			opRgb32Pck64: begin
				convVal = {32'b0, src[63:56], src[47:40], src[31:24], src[15:8]};
			end
			opRgb32Upck64: begin
				convVal = {
					src[31:24], src[31:24],
					src[23:16], src[23:16],
					src[15: 8], src[15: 8],
					src[ 7: 0], src[ 7: 0]
				};
			end
			default: convVal = '0;
		endcase
	end

	// accepts while empty or while being drained
	assign req.ready = !full || resReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			full <= 1'b0;
		end else if (req.valid && req.ready) begin
			full <= 1'b1;
		end else if (resReady) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req.valid && req.ready) begin
			resReg <= convVal;
		end
	end

	assign resValid = full;
	assign resVal   = resReg;

endmodule

//--- hdl/convCollect.sv
//--------------------
// result collector
// drains the lanes in issue order
//--------------------
module convCollect
	import convPkg::*;
#(
	parameter int NumLanes = 4
) (
	input  logic      clock,
	input  logic      arstN,
	input  logic      laneValid [NumLanes],
	input  convWord_t laneVal [NumLanes],
	output logic      laneReady [NumLanes],
	output logic      outValid,
	output convWord_t outVal,
	input  logic      outReady
);

	localparam int PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	typedef logic [PtrW-1:0] lanePtr_t;

	lanePtr_t drainPtr;

	assign outValid = laneValid[drainPtr];
	assign outVal   = laneVal[drainPtr];

	// ready goes to the pointed lane only
	for (genvar i = 0; i < NumLanes; i++) begin : genReady
		assign laneReady[i] = outReady && (drainPtr == lanePtr_t'(i));
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			drainPtr <= '0;
		end else if (outValid && outReady) begin
			if (drainPtr == lanePtr_t'(NumLanes - 1)) begin
				drainPtr <= '0;
			end else begin
				drainPtr <= drainPtr + lanePtr_t'(1);
			end
		end
	end

endmodule

//--- hdl/convUnit.sv
//--------------------
// multi-lane conversion unit
// dispatcher, registered lanes and in-order collector
//--------------------
module convUnit
	import convPkg::*;
#(
	parameter int NumLanes = 4
) (
	input  logic      clock,
	input  logic      arstN,
	input  logic      inValid,
	output logic      inReady,
	input  convOp_t   inOp,
	input  convWord_t inVal,
	output logic      outValid,
	input  logic      outReady,
	output convWord_t outVal
);

	convLaneIf laneIf [NumLanes] ();

	logic      laneValid [NumLanes];
	convWord_t laneVal [NumLanes];
	logic      laneReady [NumLanes];

	convDispatch #(
		.NumLanes (NumLanes)
	) dispatch (
		.clock   (clock),
		.arstN   (arstN),
		.inValid (inValid),
		.inOp    (inOp),
		.inVal   (inVal),
		.inReady (inReady),
		.lanes   (laneIf)
	);

	for (genvar i = 0; i < NumLanes; i++) begin : genLane
		convLane lane (
			.clock    (clock),
			.arstN    (arstN),
			.req      (laneIf[i]),
			.resValid (laneValid[i]),
			.resVal   (laneVal[i]),
			.resReady (laneReady[i])
		);
	end

	// same round-robin order as the dispatcher
	convCollect #(
		.NumLanes (NumLanes)
	) collect (
		.clock     (clock),
		.arstN     (arstN),
		.laneValid (laneValid),
		.laneVal   (laneVal),
		.laneReady (laneReady),
		.outValid  (outValid),
		.outVal    (outVal),
		.outReady  (outReady)
	);

endmodule

//--- test/convModel.svh
//--------------------
// conversion reference model
// expected result for one op and operand
//--------------------
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// 8888 pixel to 1555 keeping alpha bits unless opaque
function automatic logic [15:0] pack555(input logic [7:0] a, input logic [7:0] r,
		input logic [7:0] g, input logic [7:0] b);
	logic [15:0] p;
	p = {1'b0, r[7:3], g[7:3], b[7:3]};
	if (a[7:4] != 4'hF) begin
		p[15] = 1'b1;
		p[10] = a[7];
		p[5]  = a[6];
		p[0]  = a[5];
	end
	return p;
endfunction

// 1555 pixel back to 8888
function automatic logic [31:0] unpack555(input logic [15:0] p);
	logic [31:0] q;
	logic [4:0]  c;
	for (int i = 0; i < 3; i++) begin
		c = p[5*i +: 5];
		q[8*i +: 8] = {c, c[4:2]};
	end
	q[31:24] = p[15] ? {p[10], p[5], p[0], 5'b0} : 8'hFF;
	return q;
endfunction

function automatic convWord_t expectConv(input convOp_t op, input convWord_t v);
	convWord_t   r;
	logic [31:0] q;
	r = '0;
	case (op)
		opMov:   r = v;
		opNot:   r = ~v;
		// signed operand widens with its sign
		opExtSb: r = $signed(v[7:0]);
		opExtSw: r = $signed(v[15:0]);
		opExtSl: r = $signed(v[31:0]);
		opExtUb: r = v[7:0];
		opExtUw: r = v[15:0];
		opExtUl: r = v[31:0];
		opLdiHi:    r = v << 22;
		opLdiQHi:   r = v << 54;
		opLdiQHi16: r = v << 16;
		opLdiQHi32: r = v << 32;
		opFNeg:     r = v ^ {1'b1, 63'b0};
		opFAbs:     r = v & {1'b0, {63{1'b1}}};
		opRgbShr1:  r = (v[15:0] >> 1) & 16'h3DEF;
		opRgb5Pck32:  r = pack555(v[31:24], v[23:16], v[15:8], v[7:0]);
		opRgb5Upck32: r = unpack555(v[15:0]);
		opRgb5Pck64:  r = pack555(v[63:56], v[47:40], v[31:24], v[15:8]);
		opRgb5Upck64: begin
			q = unpack555(v[15:0]);
			for (int i = 0; i < 4; i++) begin
				r[16*i +: 16] = {2{q[8*i +: 8]}};
			end
		end
		opRgb32Pck64: begin
			for (int i = 0; i < 4; i++) begin
				r[8*i +: 8] = v[16*i+8 +: 8];
			end
		end
		opRgb32Upck64: begin
			for (int i = 0; i < 4; i++) begin
				r[16*i +: 16] = {2{v[8*i +: 8]}};
			end
		end
		default: r = '0;
	endcase
	return r;
endfunction

`endif

//--- test/convUnitTb.sv
//--------------------
// conversion unit testbench
// random ops checked against a reference model
//--------------------
module convUnitTb
	import convPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumLanes   = 4;
	localparam int NumOps     = 2000;
	localparam int CycleLimit = NumOps * 20;

	logic      clock;
	logic      arstN;
	logic      inValid;
	logic      inReady;
	convOp_t   inOp;
	convWord_t inVal;
	logic      outValid;
	logic      outReady;
	convWord_t outVal;

	convWord_t expQ [$];
	int        errors = 0;
	int        popped = 0;
	int        cycles = 0;

	`include "convModel.svh"

	convUnit #(
		.NumLanes (NumLanes)
	) dut (
		.clock    (clock),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.inOp     (inOp),
		.inVal    (inVal),
		.outValid (outValid),
		.outReady (outReady),
		.outVal   (outVal)
	);

	always #5 clock = ~clock;

	task automatic checkValue(input convWord_t got, input convWord_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic convOp_t randOp();
		return convOp_t'($urandom_range(0, 31));
	endfunction

	function automatic convWord_t randWord();
		convWord_t w;
		w = {$urandom(), $urandom()};
		// opaque alpha now and then
		if ($urandom_range(0, 3) == 0) begin
			w = w | 64'hF000_0000_F000_0000;
		end
		return w;
	endfunction

	// holds the item until the unit takes it
	task automatic sendOne(input convOp_t op, input convWord_t val);
		inValid = 1'b1;
		inOp    = op;
		inVal   = val;
		do begin
			@(posedge clock);
		end while (!inReady);
		#1;
		inValid = 1'b0;
	endtask

	task automatic drain();
		outReady = 1'b1;
		while (expQ.size() != 0) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic runRandom(input int count);
		int   sent;
		logic taken;
		sent = 0;
		while (sent < count) begin
			if (!inValid && $urandom_range(0, 3) != 0) begin
				inValid = 1'b1;
				inOp    = randOp();
				inVal   = randWord();
			end
			outReady = ($urandom_range(0, 3) != 0);
			@(posedge clock);
			taken = inValid && inReady;
			#1;
			if (taken) begin
				sent++;
				inValid = 1'b0;
			end
		end
	endtask

	// scoreboard of transfers seen at the edge
	always @(posedge clock) begin
		if (outValid && outReady) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("output transfer at %0t with no input pending", $time);
			end else begin
				checkValue(outVal, expQ.pop_front(), "result value");
				popped++;
			end
		end
		if (inValid && inReady) begin
			expQ.push_back(expectConv(inOp, inVal));
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("errors: %0d", errors);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		clock    = 1'b0;
		arstN    = 1'b0;
		inValid  = 1'b0;
		inOp     = opMov;
		inVal    = '0;
		outReady = 1'b0;
		void'($urandom(32'h2273));
		repeat (16) @(posedge clock);
		#1;
		arstN = 1'b1;
		@(posedge clock);
		#1;
		checkValue(outValid, 0, "outValid after reset");
		checkValue(inReady, 1, "inReady after reset");

		// every code once including the undefined ones
		outReady = 1'b1;
		for (int c = 0; c < 32; c++) begin
			sendOne(convOp_t'(c), randWord());
		end
		drain();

		// lanes fill while the output stalls
		outReady = 1'b0;
		for (int k = 1; k <= NumLanes; k++) begin
			sendOne(randOp(), randWord());
			checkValue(inReady, k < NumLanes, "inReady while lanes fill");
		end
		outReady = 1'b1;
		@(posedge clock);
		#1;
		outReady = 1'b0;
		checkValue(inReady, 1, "inReady after one output");
		drain();

		runRandom(NumOps);
		drain();
		checkValue(outValid, 0, "outValid after drain");
		$display("errors: %0d, results checked: %0d", errors, popped);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- convUnit.f
+incdir+test
hdl/convPkg.sv
hdl/convLaneIf.sv
hdl/convDispatch.sv
hdl/convLane.sv
hdl/convCollect.sv
hdl/convUnit.sv
test/convUnitTb.sv
